/* src/scan_pkg.sv */
`default_nettype none

package scan_pkg;

    localparam int COLORW = 4;                 // default channel width, top level may override

    typedef logic [COLORW-1:0] chan_t;        // one colour channel
    typedef logic [8:0]        haddr_t;       // horizontal address, up to 512 pixels

    typedef struct packed {
        chan_t r;                             // msb side
        chan_t g;
        chan_t b;
    } rgb_t;

    // scanline treatment on the second pass of a line
    typedef enum logic [1:0] {
        sl_none    = 2'd0,
        sl_half    = 2'd1,
        sl_quarter = 2'd2,
        sl_black   = 2'd3
    } sl_mode_t;

    // floor average of two channels
    function automatic chan_t ave_chan(input chan_t a, input chan_t b);
        logic [COLORW:0] sum;                 // one extra bit for the carry
        sum = {1'b0, a} + {1'b0, b};
        return sum[COLORW:1];
    endfunction

    function automatic rgb_t blend_rgb(input rgb_t a, input rgb_t b);
        rgb_t o;
        o.r = ave_chan(a.r, b.r);
        o.g = ave_chan(a.g, b.g);
        o.b = ave_chan(a.b, b.b);
        return o;
    endfunction

    // blend with black once (half) or twice (quarter)
    function automatic rgb_t dim_rgb(input rgb_t p, input logic twice);
        rgb_t half;
        half = blend_rgb('0, p);
        return twice ? blend_rgb('0, half) : half;
    endfunction

endpackage

`default_nettype wire

/* src/line_buffer_ram.sv */
`timescale 1ns/1ps
`default_nettype none

// two line halves, top address bit picks the half
module line_buffer_ram #(
    parameter int DW = 12,
    parameter int AW = 10
) (
    input  wire logic          clk,
    input  wire logic          wr_en,
    input  wire logic [AW-1:0] wr_addr,
    input  wire logic [DW-1:0] wr_data,
    input  wire logic [AW-1:0] rd_addr,
    output logic      [DW-1:0] rd_data
);

    logic [DW-1:0] mem [2**AW];              // no reset on storage

    // write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, data valid one clk after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

    // the doubler keeps writes on the other half from reads,
    // so a same-address collision means the ping-pong broke
    property p_no_collision;
        @(posedge clk) wr_en |-> (wr_addr != rd_addr);
    endproperty

    a_no_collision: assert property (p_no_collision)
        else $error("line buffer write and read hit address %0h", wr_addr);

endmodule

`default_nettype wire

/* src/raster_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module raster_timing #(
    parameter int H_TOTAL  = 400,             // input pixels per line
    parameter int HS_START = 320,
    parameter int HS_WIDTH = 32
) (
    input  wire logic clk,
    input  wire logic rst_n,
    output logic      pxl_cen,                // input pixel strobe, 1 in 8 clk
    output logic      pxl2_cen,               // doubled pixel strobe, 1 in 4 clk
    output logic      hs                      // input horizontal sync
);

    import scan_pkg::*;

    localparam int HS_END = HS_START + HS_WIDTH;

    logic [1:0] phase;                        // clk phase within a doubled pixel
    logic       tgl;                          // halves pxl2_cen
    haddr_t     hcnt;                         // input pixel position
    haddr_t     hcnt_nxt;
    logic       hs_nxt;

    // clock enables
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase    <= '0;
            tgl      <= 1'b0;
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
        end else begin
            phase    <= phase + 2'd1;
            pxl2_cen <= (phase == 2'd3);
            pxl_cen  <= (phase == 2'd3) && tgl;   // every second strobe
            if (phase == 2'd3) begin
                tgl <= ~tgl;
            end
        end
    end

    // next horizontal position and sync level
    always_comb begin
        if (hcnt == haddr_t'(H_TOTAL - 1)) begin
            hcnt_nxt = '0;                    // wrap at end of line
        end else begin
            hcnt_nxt = hcnt + 9'd1;
        end
        hs_nxt = (hcnt_nxt >= haddr_t'(HS_START)) && (hcnt_nxt < haddr_t'(HS_END));
    end

    // horizontal counter, one step per input pixel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hcnt <= '0;
            hs   <= 1'b0;
        end else if (pxl_cen) begin
            hcnt <= hcnt_nxt;
            hs   <= hs_nxt;                   // sync tracks the counter
        end
    end

    // pixel strobe must sit on a doubled strobe, the doubler depends on it
    property p_cen_aligned;
        @(posedge clk) disable iff (!rst_n) pxl_cen |-> pxl2_cen;
    endproperty

    a_cen_aligned: assert property (p_cen_aligned)
        else $error("pxl_cen high without pxl2_cen");

endmodule

`default_nettype wire

/* src/scan_doubler.sv */
`timescale 1ns/1ps
`default_nettype none

module scan_doubler #(
    parameter int COLORW = 4
) (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic                                pxl_cen,
    input  wire logic                                pxl2_cen,
    input  wire scan_pkg::rgb_t                      base_pxl,
    input  wire logic                                hs,
    input  wire logic                                blend_en,
    input  wire scan_pkg::sl_mode_t                  sl_mode,
    output logic                                     wr_en,
    output logic [$bits(scan_pkg::haddr_t):0]        wr_addr,
    output scan_pkg::rgb_t                           wr_data,
    output logic [$bits(scan_pkg::haddr_t):0]        rd_addr,
    input  wire scan_pkg::rgb_t                      rd_data,
    output scan_pkg::rgb_t                           x2_pxl,
    output logic                                     x2_hs
);

    import scan_pkg::*;

    localparam int DW = 3 * COLORW;           // pixel width

    // the pixel type is fixed by the package width
    if (DW != $bits(rgb_t)) begin : g_width_chk
        $error("COLORW %0d does not match rgb_t width", COLORW);
    end

    haddr_t     wr_h;                         // write position in line
    haddr_t     rd_h;                         // read position in line
    haddr_t     hlen;                         // last position of the stored line
    haddr_t     hswidth;                      // hs width in input pixels
    logic       line;                         // half being read
    logic       scanline;                     // second pass of the line
    logic       last_hs;
    logic       alt_pxl;                      // previous strobe carried pxl_cen
    logic [2:0] cen_d;                        // pxl2_cen delayed 1..3 clk
    rgb_t       prev_rd;                      // left neighbour in this pass
    rgb_t       blend_q;                      // blend stage output
    logic       hs_rise;
    logic       hs_fall;

    assign hs_rise = hs && !last_hs;
    assign hs_fall = !hs && last_hs;

    // line buffer ports, halves kept apart
    assign wr_en   = pxl_cen;
    assign wr_data = base_pxl;
    assign wr_addr = {~line, wr_h};
    assign rd_addr = {line, rd_h};

    // address control, all on the doubled strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_h     <= '0;
            rd_h     <= '0;
            hlen     <= '1;                   // no wrap before first line
            hswidth  <= '0;
            line     <= 1'b0;
            scanline <= 1'b0;
            last_hs  <= 1'b0;
            alt_pxl  <= 1'b0;
            x2_hs    <= 1'b0;
        end else if (pxl2_cen) begin
            last_hs <= hs;
            alt_pxl <= pxl_cen;
            if (hs_rise) begin
                hlen     <= wr_h;             // length of the line just written
                wr_h     <= '0;
                rd_h     <= '0;
                line     <= ~line;            // swap halves
                scanline <= 1'b0;
                x2_hs    <= 1'b1;
            end else begin
                if (alt_pxl) begin
                    wr_h <= wr_h + 9'd1;      // once per input pixel
                end
                if (rd_h == hlen) begin
                    rd_h     <= '0;           // second repetition
                    scanline <= 1'b1;
                    x2_hs    <= 1'b1;
                end else begin
                    rd_h <= rd_h + 9'd1;
                    if (rd_h == hswidth) begin
                        x2_hs <= 1'b0;
                    end
                end
            end
            if (hs_fall) begin
                hswidth <= wr_h;
            end
        end
    end

    // strobe pipeline for the RAM, blend and shade stages
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cen_d <= '0;
        end else begin
            cen_d <= {cen_d[1:0], pxl2_cen};
        end
    end

    // blend stage, rd_data valid two clk after the strobe
    always_ff @(posedge clk) begin
        if (cen_d[1]) begin
            prev_rd <= rd_data;
            if (blend_en) begin
                // first pixel of a pass mixes with black
                blend_q <= blend_rgb((rd_h == '0) ? rgb_t'('0) : prev_rd, rd_data);
            end else begin
                blend_q <= rd_data;
            end
        end
    end

    // shade stage, output held for the whole slot
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x2_pxl <= '0;
        end else if (cen_d[2]) begin
            if (!scanline) begin
                x2_pxl <= blend_q;            // first pass untouched
            end else begin
                case (sl_mode)
                    sl_none:    x2_pxl <= blend_q;
                    sl_half:    x2_pxl <= dim_rgb(blend_q, 1'b0);
                    sl_quarter: x2_pxl <= dim_rgb(blend_q, 1'b1);
                    default:    x2_pxl <= '0;     // black scanline
                endcase
            end
        end
    end

    // read side must stay inside the stored line
    property p_rd_in_line;
        @(posedge clk) disable iff (!rst_n) rd_h <= hlen;
    endproperty

    a_rd_in_line: assert property (p_rd_in_line)
        else $error("read address %0d beyond line length %0d", rd_h, hlen);

endmodule

`default_nettype wire

/* src/scan_video_top.sv */
`timescale 1ns/1ps
`default_nettype none

module scan_video_top #(
    parameter int COLORW   = scan_pkg::COLORW,
    parameter int H_TOTAL  = 400,
    parameter int HS_START = 320,
    parameter int HS_WIDTH = 32
) (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire scan_pkg::rgb_t     base_pxl,
    input  wire logic               blend_en,
    input  wire scan_pkg::sl_mode_t sl_mode,
    output logic                    pxl_cen,
    output logic                    pxl2_cen,
    output logic                    hs,
    output scan_pkg::rgb_t          x2_pxl,
    output logic                    x2_hs
);

    import scan_pkg::*;

    localparam int AW = $bits(haddr_t) + 1;   // half bit on top

    logic          wr_en;
    logic [AW-1:0] wr_addr;
    logic [AW-1:0] rd_addr;
    rgb_t          wr_data;
    rgb_t          rd_data;

    raster_timing #(
        .H_TOTAL  (H_TOTAL),
        .HS_START (HS_START),
        .HS_WIDTH (HS_WIDTH)
    ) u_timing (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .pxl2_cen (pxl2_cen),
        .hs       (hs)
    );

    scan_doubler #(
        .COLORW   (COLORW)
    ) u_doubler (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .pxl2_cen (pxl2_cen),
        .base_pxl (base_pxl),
        .hs       (hs),
        .blend_en (blend_en),
        .sl_mode  (sl_mode),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .x2_pxl   (x2_pxl),
        .x2_hs    (x2_hs)
    );

    line_buffer_ram #(
        .DW       (3 * COLORW),
        .AW       (AW)
    ) u_buffer (
        .clk      (clk),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

endmodule

`default_nettype wire

/* bench/tb_scan_video.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_scan_video;

    import scan_pkg::*;

    localparam int H_TOTAL        = 40;
    localparam int HS_START       = 32;
    localparam int HS_WIDTH       = 4;
    localparam int CLK_PERIOD     = 40;
    localparam int DRIVE_DLY      = 1;              // after the rising edge
    localparam int H_MAX          = 512;
    localparam int LINE_CLK       = H_TOTAL * 8;    // 8 clk per input pixel
    localparam int LINE_TESTS     = 5;
    localparam int LINES_PER_TEST = 3;
    // line tests plus reset, partial first line and lead-in, doubled for margin
    localparam int CYCLE_LIMIT    = (LINE_TESTS * LINES_PER_TEST + 3) * LINE_CLK * 2;

    logic     clk;
    logic     rst_n;
    rgb_t     base_pxl;
    logic     blend_en;
    sl_mode_t sl_mode;
    logic     pxl_cen;
    logic     pxl2_cen;
    logic     hs;
    rgb_t     x2_pxl;
    logic     x2_hs;

    rgb_t     store_px [2][H_MAX];                  // closed input lines, by line parity
    int       store_len [2];
    bit       store_ok [2];                         // line began at an hs edge
    rgb_t     cap_px [H_MAX];                       // line being written

    int       out_line = -1;                        // output line being read out
    int       pix_err = 0;
    int       pix_checks = 0;
    int       sync_err = 0;
    int       sync_checks = 0;
    int       rst_err = 0;
    int       n_pass = 0;
    int       n_fail = 0;
    int       seed = 3;
    event     line_start;

    scan_video_top #(
        .COLORW   (COLORW),
        .H_TOTAL  (H_TOTAL),
        .HS_START (HS_START),
        .HS_WIDTH (HS_WIDTH)
    ) UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .base_pxl (base_pxl),
        .blend_en (blend_en),
        .sl_mode  (sl_mode),
        .pxl_cen  (pxl_cen),
        .pxl2_cen (pxl2_cen),
        .hs       (hs),
        .x2_pxl   (x2_pxl),
        .x2_hs    (x2_hs)
    );

    // per channel floor mean
    function automatic rgb_t avg_pixel(input rgb_t a, input rgb_t b);
        rgb_t o;
        o.r = chan_t'((int'(a.r) + int'(b.r)) >> 1);
        o.g = chan_t'((int'(a.g) + int'(b.g)) >> 1);
        o.b = chan_t'((int'(a.b) + int'(b.b)) >> 1);
        return o;
    endfunction

    function automatic rgb_t shift_pixel(input rgb_t p, input int n);
        rgb_t o;
        o.r = p.r >> n;                             // n=1 half, n=2 quarter
        o.g = p.g >> n;
        o.b = p.b >> n;
        return o;
    endfunction

    // expected x2_pxl for one read slot of a stored line
    function automatic rgb_t ref_pixel(input int bank, input int slot, input bit scan,
                                       input bit blend, input sl_mode_t mode);
        rgb_t cur;
        rgb_t left;
        rgb_t px;
        cur  = store_px[bank][slot];
        left = (slot == 0) ? rgb_t'('0) : store_px[bank][slot-1];   // black left of pixel 0
        px   = blend ? avg_pixel(cur, left) : cur;
        if (scan) begin
            case (mode)
                sl_half:    px = shift_pixel(px, 1);
                sl_quarter: px = shift_pixel(px, 2);
                sl_black:   px = '0;
                default:    px = px;
            endcase
        end
        return px;
    endfunction

    task automatic report_test(input string name, input int errs, input int checks);
        if (checks == 0) begin
            n_fail++;
            $display("%-18s nothing was compared, test did not run", name);
        end else if (errs != 0) begin
            n_fail++;
            $display("%-18s FAIL  %0d of %0d checks wrong", name, errs, checks);
        end else begin
            n_pass++;
            $display("%-18s ok    %0d checks", name, checks);
        end
    endtask

    // outputs quiet, enables too while in reset
    task automatic check_quiet(inout int n);
        n += 2;
        if (x2_hs !== 1'b0) begin
            rst_err++;
            $display("** Error at %0t: x2_hs expected 0, got %b", $time, x2_hs);
        end
        if (x2_pxl !== rgb_t'('0)) begin
            rst_err++;
            $display("** Error at %0t: x2_pxl expected %h, got %h", $time, rgb_t'('0), x2_pxl);
        end
        if (!rst_n) begin
            n++;
            if ({pxl_cen, pxl2_cen, hs} !== 3'b000) begin
                rst_err++;
                $display("** Error at %0t: {pxl_cen,pxl2_cen,hs} expected 000, got %b",
                         $time, {pxl_cen, pxl2_cen, hs});
            end
        end
    endtask

    task automatic check_reset();
        int n;
        n     = 0;
        rst_n = 1'b0;
        repeat (8) begin
            @(posedge clk);
            #(DRIVE_DLY);
            check_quiet(n);
        end
        rst_n = 1'b1;                               // release 8 cycles in
        repeat (2) begin
            @(posedge clk);
            #(DRIVE_DLY);
            check_quiet(n);
        end
        report_test("reset state", rst_err, n);
    endtask

    // modes move only on an output line boundary
    task automatic run_lines(input string name, input bit blend, input sl_mode_t mode);
        int err0;
        int chk0;
        err0     = pix_err;
        chk0     = pix_checks;
        blend_en = blend;
        sl_mode  = mode;
        repeat (LINES_PER_TEST) @(line_start);
        report_test(name, pix_err - err0, pix_checks - chk0);
    endtask

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("run timed out after %0d clk cycles", cycles);
        $display("Test failed");
        $finish;
    end

    // host pixel source, also records each line as written
    initial begin : stimulus
        int          wr_idx;
        int          n_lines;
        bit          cen_q;                         // pxl_cen during the clk just ended
        bit          hs_q;
        bit          started;
        logic [31:0] rnd;
        wr_idx   = 0;
        n_lines  = 0;
        cen_q    = 1'b0;
        hs_q     = 1'b0;
        started  = 1'b0;
        base_pxl = '0;
        @(posedge rst_n);
        forever begin
            @(posedge clk);
            #(DRIVE_DLY);
            if (cen_q) begin
                cap_px[wr_idx] = base_pxl;          // taken on the edge just passed
                wr_idx++;
            end
            if (hs && !hs_q) begin
                for (int i = 0; i < wr_idx; i++) begin
                    store_px[n_lines % 2][i] = cap_px[i];
                end
                store_len[n_lines % 2] = wr_idx;
                store_ok[n_lines % 2]  = started;   // first line after reset is partial
                n_lines++;
                wr_idx  = 0;
                started = 1'b1;
            end
            if (cen_q) begin
                rnd      = $random(seed);
                base_pxl = rnd[$bits(rgb_t)-1:0];   // stable until the next write
            end
            cen_q = pxl_cen;
            hs_q  = hs;
        end
    end

    // slot tracking, pixel compare and sync checks
    initial begin : compare
        bit   stb_q;
        bit   hs_q;
        bit   hs_s;                                 // hs at the last strobe
        bit   xhs_q;
        bit   xhs_s;
        bit   pass2;
        bit   line_ok;
        bit   chk_on;
        bit   chk_pass2;
        int   bank;
        int   slot;
        int   chk_bank;
        int   chk_slot;
        int   pend;
        int   hi_cnt;
        int   rises;
        rgb_t expect_px;
        {stb_q, hs_q, hs_s, xhs_q, xhs_s} = '0;
        {pass2, line_ok, chk_on, chk_pass2} = '0;
        {bank, slot, chk_bank, chk_slot, pend, hi_cnt, rises} = '0;
        @(posedge rst_n);
        forever begin
            @(posedge clk);
            #(DRIVE_DLY);
            if (pend > 0) begin
                pend--;
                if (pend == 0 && chk_on) begin      // 3 clk after the strobe
                    expect_px = ref_pixel(chk_bank, chk_slot, chk_pass2, blend_en, sl_mode);
                    pix_checks++;
                    if (x2_pxl !== expect_px) begin
                        pix_err++;
                        $display("** Error at %0t: x2_pxl expected %h, got %h (slot %0d pass %0d)",
                                 $time, expect_px, x2_pxl, chk_slot, chk_pass2 + 1);
                    end
                end
            end
            if (stb_q) begin
                if (hs_q && !hs_s) begin            // input line boundary
                    if (line_ok) begin
                        sync_checks++;
                        if (rises != 2) begin
                            sync_err++;
                            $display("x2_hs rose %0d times in output line %0d, two expected",
                                     rises, out_line);
                        end
                    end
                    out_line++;
                    bank    = out_line % 2;
                    slot    = 0;
                    pass2   = 1'b0;
                    rises   = 0;
                    line_ok = store_ok[bank];
                    -> line_start;
                end else if (out_line >= 0) begin
                    slot++;
                    if (slot == store_len[bank]) begin
                        slot  = 0;                  // scanline repetition starts
                        pass2 = 1'b1;
                    end
                end
                hs_s = hs_q;
                if (xhs_q && !xhs_s) begin
                    rises++;
                    hi_cnt = 1;
                end else if (xhs_q) begin
                    hi_cnt++;
                end else if (xhs_s && line_ok) begin
                    sync_checks++;                  // pulse just ended
                    if (hi_cnt != HS_WIDTH) begin
                        sync_err++;
                        $display("** Error at %0t: x2_hs high strobes expected %0d, got %0d",
                                 $time, HS_WIDTH, hi_cnt);
                    end
                end
                xhs_s     = xhs_q;
                chk_on    = line_ok;
                chk_bank  = bank;
                chk_slot  = slot;
                chk_pass2 = pass2;
                pend      = 3;
            end
            stb_q = pxl2_cen;
            hs_q  = hs;
            xhs_q = x2_hs;
        end
    end

    initial begin : main
        $timeformat(-9, 0, " ns", 1);
        rst_n    = 1'b0;
        blend_en = 1'b0;
        sl_mode  = sl_none;
        check_reset();
        while (out_line < 1) begin
            @(line_start);                          // skip the partial first line
        end
        run_lines("line doubling", 1'b0, sl_none);
        run_lines("neighbour blend", 1'b1, sl_none);
        run_lines("scanline half", 1'b0, sl_half);
        run_lines("scanline quarter", 1'b1, sl_quarter);
        run_lines("scanline black", 1'b0, sl_black);
        report_test("x2_hs sync", sync_err, sync_checks);
        $display("tests passed %0d, failed %0d (pixel checks %0d, sync checks %0d)",
                 n_pass, n_fail, pix_checks, sync_checks);
        if (n_fail == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
src/scan_pkg.sv
src/line_buffer_ram.sv
src/raster_timing.sv
src/scan_doubler.sv
src/scan_video_top.sv
bench/tb_scan_video.sv
